// File: Bender.yml
package:
  name: rtc_menu

sources:
  - src/rtcPkg.sv
  - src/rtcBusIf.sv
  - src/alarmTimer.sv
  - src/shadowRegs.sv
  - src/rtcBusArbiter.sv
  - src/menuEditor.sv
  - src/rtcSweeper.sv
  - src/rtcMenuTop.sv
  - target: test
    files:
      - bench/rtcDeviceModel.sv
      - bench/tbRtcMenu.sv

// File: bench/rtcDeviceModel.sv
// Behavioural RTC, a register file behind the level and pulse bus
module rtcDeviceModel
(
	input  logic                     CLK,
	input  logic                     RST,
	input  logic                     rtcReq,
	input  logic [rtcPkg::addrW-1:0] rtcAddr,
	input  logic [rtcPkg::dataW-1:0] rtcWrData,
	input  logic                     rtcWrite,
	output logic                     rtcDone,
	output logic [rtcPkg::dataW-1:0] rtcRdData,
	output int                       logCount     // Accesses logged so far
);

	logic [rtcPkg::dataW-1:0] regs [256];       // Register file
	logic [rtcPkg::addrW-1:0] logAddr [$];      // Access log, one entry per done
	logic [rtcPkg::dataW-1:0] logData [$];      // Write data or returned read data
	logic logWrite [$];
	logic initPend;                             // Init finished pulse still due
	logic busy;                                 // Request accepted, counting down
	logic [1:0] delay;                          // Cycles left minus one

	//////////////////////////////////////////////////
	always @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			for (int i = 0; i < 256; i++)
				regs[i] <= 8'($urandom);              // Random power-up contents
			rtcDone <= 1'b0;
			rtcRdData <= '0;
			initPend <= 1'b1;
			busy <= 1'b0;
			delay <= '0;
			logCount <= 0;
			logAddr.delete();
			logData.delete();
			logWrite.delete();
		end
		else
		begin
			rtcDone <= 1'b0;
			if (initPend)
			begin
				rtcDone <= 1'b1;                      // Init finished, no access
				initPend <= 1'b0;
			end
			else if (busy)
			begin
				if (delay == 0)
				begin
					rtcDone <= 1'b1;
					busy <= 1'b0;
					logAddr.push_back(rtcAddr);
					logWrite.push_back(rtcWrite);
					logCount <= logCount + 1;
					if (rtcWrite)
					begin
						regs[rtcAddr] <= rtcWrData;
						logData.push_back(rtcWrData);
					end
					else
					begin
						rtcRdData <= regs[rtcAddr];       // Valid with done
						logData.push_back(regs[rtcAddr]);
					end
				end
				else
					delay <= delay - 1'b1;
			end
			else if (rtcReq && !rtcDone)              // Req still high on the done cycle
			begin
				busy <= 1'b1;
				delay <= 2'($urandom_range(3, 0));    // 1 to 4 cycles
			end
		end
	end

endmodule

// File: bench/tbRtcMenu.sv
module tbRtcMenu;

	typedef enum logic [2:0]
	{
		opLeft,
		opRight,
		opUp,
		opDown,
		opCentre,
		opIrq
	} opKind;

	// One table row with the pointer expected after the step
	typedef struct packed
	{
		opKind op;
		logic [6:0] punt;
		logic chkVal;            // Compare curVal with the RTC register at punt
		logic [7:0] wrAddr;      // Expected write address or zero for none
	} stepRow;

	localparam int nSteps = 19;

	logic CLK;
	logic RST;
	logic irq;
	logic left;
	logic right;
	logic up;
	logic down;
	logic centre;
	logic rtcDone;
	logic [7:0] rtcRdData;
	logic rtcReq;
	logic [7:0] rtcAddr;
	logic [7:0] rtcWrData;
	logic rtcWrite;
	logic [6:0] punt;
	logic [7:0] curVal;
	logic alarm;
	logic stw;
	int logCount;

	stepRow steps [nSteps];
	int errors;
	int checks;
	int tests;
	int failedTests;
	bit aborted;             // Set by a timeout to skip the remaining steps

	rtcMenuTop i_rtcMenuTop
	(
		.CLK(CLK), .RST(RST), .irq(irq), .left(left), .right(right), .up(up), .down(down),
		.centre(centre), .rtcDone(rtcDone), .rtcRdData(rtcRdData), .rtcReq(rtcReq),
		.rtcAddr(rtcAddr), .rtcWrData(rtcWrData), .rtcWrite(rtcWrite), .punt(punt),
		.curVal(curVal), .alarm(alarm), .stw(stw)
	);

	rtcDeviceModel i_rtcDeviceModel
	(
		.CLK(CLK), .RST(RST), .rtcReq(rtcReq), .rtcAddr(rtcAddr), .rtcWrData(rtcWrData),
		.rtcWrite(rtcWrite), .rtcDone(rtcDone), .rtcRdData(rtcRdData), .logCount(logCount)
	);

	always #10 CLK = ~CLK;                      // 20 unit period

	////////////////////////////////////////////////// Helpers
	function automatic stepRow makeRow(input opKind op, input logic [6:0] p, input logic chk,
		input logic [7:0] wa);
		stepRow r;
		r.op = op;
		r.punt = p;
		r.chkVal = chk;
		r.wrAddr = wa;
		return r;
	endfunction

	// Map order with the low window first
	function automatic logic [7:0] sweepAddr(input int k);
		return (k < 7) ? 8'(8'h21 + k) : 8'(8'h41 + k - 7);
	endfunction

	task automatic loadTable();
		steps[0] = makeRow(opRight, 7'h44, 1'b1, 8'h00);     // Wrap to the end
		steps[1] = makeRow(opLeft, 7'h21, 1'b1, 8'h00);      // Wrap to the start
		steps[2] = makeRow(opLeft, 7'h22, 1'b1, 8'h00);
		steps[3] = makeRow(opRight, 7'h21, 1'b1, 8'h00);
		steps[4] = makeRow(opRight, 7'h44, 1'b1, 8'h00);
		steps[5] = makeRow(opRight, 7'h43, 1'b1, 8'h00);
		steps[6] = makeRow(opRight, 7'h42, 1'b1, 8'h00);
		steps[7] = makeRow(opRight, 7'h41, 1'b1, 8'h00);
		steps[8] = makeRow(opRight, 7'h27, 1'b1, 8'h00);     // Back over the gap
		steps[9] = makeRow(opLeft, 7'h41, 1'b1, 8'h00);      // Forward over the gap
		steps[10] = makeRow(opLeft, 7'h42, 1'b1, 8'h00);
		steps[11] = makeRow(opUp, 7'h42, 1'b0, 8'h42);
		steps[12] = makeRow(opLeft, 7'h43, 1'b1, 8'h00);
		steps[13] = makeRow(opDown, 7'h43, 1'b0, 8'h43);
		steps[14] = makeRow(opLeft, 7'h44, 1'b1, 8'h00);
		steps[15] = makeRow(opLeft, 7'h21, 1'b1, 8'h00);
		steps[16] = makeRow(opIrq, 7'h21, 1'b1, 8'h00);
		steps[17] = makeRow(opRight, 7'h44, 1'b1, 8'h00);
		steps[18] = makeRow(opCentre, 7'h21, 1'b0, 8'h00);   // Then the command write
	endtask

	task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			$display("Fail at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic timedOut(input string what);
		$display("Timeout at %0t while waiting for %s", $time, what);
		errors++;
		aborted = 1'b1;
	endtask

	task automatic endTest(input string name, input int errStart);
		tests++;
		if (errors != errStart)
		begin
			failedTests++;
			$display("Test %0d %s: failed with %0d errors", tests, name, errors - errStart);
		end
		else
			$display("Test %0d %s: passed", tests, name);
	endtask

	////////////////////////////////////////////////// Waits with their own limits
	task automatic waitLog(input int n, input int limit, input string what);
		int k;
		k = 0;
		while ((logCount < n) && (k < limit))
		begin
			@(negedge CLK);
			k++;
		end
		if (logCount < n)
			timedOut(what);
	endtask

	// First write logged at or after from
	task automatic waitWrite(input int from, input int limit, output int at);
		at = -1;
		for (int k = 0; (k < limit) && (at < 0); k++)
		begin
			@(negedge CLK);
			for (int j = from; j < logCount; j++)
				if ((at < 0) && i_rtcDeviceModel.logWrite[j])
					at = j;
		end
		if (at < 0)
			timedOut("an RTC write");
	endtask

	task automatic waitReads(input logic [7:0] addr, input int from, input int count,
		input int limit);
		int seen;
		seen = 0;
		for (int k = 0; (k < limit) && (seen < count); k++)
		begin
			@(negedge CLK);
			seen = 0;
			for (int j = from; j < logCount; j++)
				if (!i_rtcDeviceModel.logWrite[j] && (i_rtcDeviceModel.logAddr[j] == addr))
					seen++;
		end
		if (seen < count)
			timedOut("further sweeps");
	endtask

	// Editor is idle again once the RTC request drops
	task automatic waitBusIdle();
		int k;
		k = 0;
		while (rtcReq && (k < 50))
		begin
			@(negedge CLK);
			k++;
		end
		if (rtcReq)
			timedOut("the RTC bus to go idle");
	endtask

	////////////////////////////////////////////////// Stimulus
	task automatic press(input opKind op);
		@(negedge CLK);
		case (op)
			opLeft: left = 1'b1;
			opRight: right = 1'b1;
			opUp: up = 1'b1;
			opDown: down = 1'b1;
			default: centre = 1'b1;
		endcase
		@(negedge CLK);
		{left, right, up, down, centre} = '0;            // One-cycle pulse
	endtask

	// Alarm high for three cycles from one cycle after irq with the strobe in the last
	task automatic checkAlarm();
		@(negedge CLK);
		checkVal("alarm", alarm, 0);
		irq = 1'b1;
		for (int k = 0; k < 4; k++)
		begin
			@(negedge CLK);
			irq = 1'b0;
			checkVal("alarm", alarm, k < 3);
			checkVal("stw", stw, k == 2);
		end
	endtask

	// Command write right after the sweep ends and never again
	task automatic checkCommand(input int from);
		int at;
		int extra;
		waitWrite(from, 500, at);
		if (at >= 0)
		begin
			checkVal("command rtcAddr", i_rtcDeviceModel.logAddr[at], 8'hF0);
			checkVal("command rtcWrData", i_rtcDeviceModel.logData[at], 0);
			checkVal("rtcAddr before command", i_rtcDeviceModel.logAddr[at - 1], 8'h44);
			waitReads(8'h44, at + 1, 2, 1000);
			extra = 0;
			for (int j = at + 1; j < logCount; j++)
				if (i_rtcDeviceModel.logWrite[j])
					extra++;
			checkVal("writes after command", extra, 0);
		end
	endtask

	task automatic applyStep(input int i);
		stepRow s;
		string name;
		int errStart;
		int logStart;
		int at;
		logic [7:0] expData;
		s = steps[i];
		name = $sformatf("step %0d %s", i, s.op.name());
		errStart = errors;
		logStart = logCount;
		expData = '0;
		if (s.op == opUp)
			expData = i_rtcDeviceModel.regs[s.wrAddr] + 8'd1;       // Wraps at 8 bits
		else if (s.op == opDown)
			expData = i_rtcDeviceModel.regs[s.wrAddr] - 8'd1;
		if (s.op == opIrq)
			checkAlarm();
		else
			press(s.op);
		checkVal("punt", punt, s.punt);
		if (s.chkVal)
			checkVal("curVal", curVal, i_rtcDeviceModel.regs[s.punt]);
		if (s.wrAddr != 0)
		begin
			waitWrite(logStart, 100, at);
			if (at >= 0)
			begin
				checkVal("rtcAddr", i_rtcDeviceModel.logAddr[at], s.wrAddr);
				checkVal("rtcWrData", i_rtcDeviceModel.logData[at], expData);
				waitBusIdle();
			end
		end
		if ((s.op == opCentre) && !aborted)
			checkCommand(logStart);
		endTest(name, errStart);
	endtask

	////////////////////////////////////////////////// Main sequence
	initial
	begin
		int errStart;
		void'($urandom(32'h9785));
		CLK = 1'b0;
		RST = 1'b1;
		{irq, left, right, up, down, centre} = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		failedTests = 0;
		aborted = 1'b0;
		loadTable();
		repeat (8) @(negedge CLK);
		RST = 1'b0;
		@(negedge CLK);

		errStart = errors;
		checkVal("rtcReq", rtcReq, 0);
		checkVal("rtcWrite", rtcWrite, 0);
		checkVal("alarm", alarm, 0);
		checkVal("stw", stw, 0);
		checkVal("punt", punt, 7'h21);
		endTest("reset values", errStart);

		// First sweep of eleven reads in map order
		errStart = errors;
		waitLog(11, 400, "the first sweep");
		if (!aborted)
			for (int k = 0; k < 11; k++)
			begin
				checkVal($sformatf("sweep %0d rtcAddr", k), i_rtcDeviceModel.logAddr[k],
					sweepAddr(k));
				checkVal($sformatf("sweep %0d rtcWrite", k), i_rtcDeviceModel.logWrite[k], 0);
			end
		endTest("first sweep order", errStart);

		for (int i = 0; (i < nSteps) && !aborted; i++)
			applyStep(i);

		$display("Tests %0d, failed %0d, checks %0d, errors %0d", tests, failedTests, checks,
			errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: compile.f
src/rtcPkg.sv
src/rtcBusIf.sv
src/alarmTimer.sv
src/shadowRegs.sv
src/rtcBusArbiter.sv
src/menuEditor.sv
src/rtcSweeper.sv
src/rtcMenuTop.sv
bench/rtcDeviceModel.sv
bench/tbRtcMenu.sv

// File: src/alarmTimer.sv
module alarmTimer
(
	input  logic CLK,
	input  logic RST,
	input  logic irq,       // RTC interrupt pulse
	output logic alarm,
	output logic stw        // Stopwatch strobe
);

	typedef enum logic
	{
		aIdle,
		aRing
	} alarmState;

	alarmState state;
	logic [rtcPkg::alarmW-1:0] cnt;    // Cycle within the pulse
	logic lastCycle;

	assign lastCycle = cnt == rtcPkg::alarmLast;

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			state <= aIdle;
			cnt <= '0;
		end
		else
		begin
			case (state)
				aIdle:
					if (irq)
					begin
						state <= aRing;                        // Pulse starts next cycle
						cnt <= '0;
					end
				aRing:
					if (lastCycle)
					begin
						state <= aIdle;
						cnt <= '0;
					end
					else
						cnt <= cnt + 1'b1;                     // IRQ ignored while ringing
				default:
					state <= aIdle;
			endcase
		end
	end

	assign alarm = state == aRing;
	assign stw = alarm && lastCycle;                      // Last cycle of the pulse

endmodule

// File: src/menuEditor.sv
module menuEditor
(
	input  logic                     CLK,
	input  logic                     RST,
	input  logic                     left,
	input  logic                     right,
	input  logic                     up,
	input  logic                     down,
	input  logic                     centre,
	input  logic [rtcPkg::dataW-1:0] curVal,   // Shadow value at punt
	rtcBusIf.requester               bus,
	output logic [rtcPkg::ptrW-1:0]  punt,
	output logic                     commit
);

	logic busy;                 // Write outstanding
	logic wrStart;
	rtcPkg::rtcAccess wrAcc;

	assign busy = bus.req;

	// Up/down only when no other button is pressed
	assign wrStart = !busy && !centre && !left && !right && (up || down);

	// Write of shadow value plus or minus one, wraps at 8 bits
	always_comb
	begin
		wrAcc.addr = {{(rtcPkg::addrW - rtcPkg::ptrW){1'b0}}, punt};
		wrAcc.data = up ? curVal + 1'b1 : curVal - 1'b1;
		wrAcc.write = 1'b1;
	end

	////////////////////////////////////////////////// Edit pointer
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			punt <= rtcPkg::firstLo[rtcPkg::ptrW-1:0];
			commit <= 1'b0;
		end
		else
		begin
			commit <= 1'b0;
			if (!busy)                                   // Buttons ignored during a write
			begin
				if (centre)
				begin
					punt <= rtcPkg::firstLo[rtcPkg::ptrW-1:0];
					commit <= 1'b1;                        // One-cycle commit pulse
				end
				else if (left)
					punt <= rtcPkg::nextPtr(punt, 1'b1);
				else if (right)
					punt <= rtcPkg::nextPtr(punt, 1'b0);
			end
		end
	end

	////////////////////////////////////////////////// Write request
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			bus.req <= 1'b0;
		else if (bus.done && bus.req)
			bus.req <= 1'b0;                             // Drop after done
		else if (wrStart)
			bus.req <= 1'b1;
	end

	always_ff @(posedge CLK)
	begin
		if (wrStart)
			bus.acc <= wrAcc;                            // Held until done
	end

endmodule

// File: src/rtcBusArbiter.sv
module rtcBusArbiter
(
	input  logic                     CLK,
	input  logic                     RST,
	rtcBusIf.arbiter                 sweepBus,
	rtcBusIf.arbiter                 editBus,
	output logic                     rtcReq,
	output logic [rtcPkg::addrW-1:0] rtcAddr,
	output logic [rtcPkg::dataW-1:0] rtcWrData,
	output logic                     rtcWrite,
	input  logic                     rtcDone,
	input  logic [rtcPkg::dataW-1:0] rtcRdData
);

	typedef enum logic [1:0]
	{
		oIdle,
		oSweep,
		oEdit
	} ownerState;

	ownerState owner;
	rtcPkg::rtcAccess outAcc;       // Access presented to the RTC

	////////////////////////////////////////////////// Grant FSM
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			owner <= oIdle;
			rtcReq <= 1'b0;
			outAcc <= '0;
		end
		else
		begin
			case (owner)
				oIdle:
					if (editBus.req)                           // Editor wins a tie
					begin
						owner <= oEdit;
						rtcReq <= 1'b1;
						outAcc <= editBus.acc;
					end
					else if (sweepBus.req)
					begin
						owner <= oSweep;
						rtcReq <= 1'b1;
						outAcc <= sweepBus.acc;
					end
				default:
					if (rtcDone)                               // Release, idle one cycle
					begin
						owner <= oIdle;
						rtcReq <= 1'b0;
					end
			endcase
		end
	end

	assign rtcAddr = outAcc.addr;
	assign rtcWrData = outAcc.data;
	assign rtcWrite = outAcc.write;

	// Done back to the owner only
	// The init pulse arrives while idle and belongs to the sweeper
	assign sweepBus.done = rtcDone && (owner != oEdit);
	assign editBus.done = rtcDone && (owner == oEdit);
	assign sweepBus.rdData = (owner != oEdit) ? rtcRdData : '0;
	assign editBus.rdData = (owner == oEdit) ? rtcRdData : '0;

endmodule

// File: src/rtcBusIf.sv
// Requester side of the RTC register bus
// Req is a level held with a stable acc until the done pulse
interface rtcBusIf;

	logic req;                          // Level request
	rtcPkg::rtcAccess acc;              // Address, data, direction
	logic done;                         // One-cycle completion pulse
	logic [rtcPkg::dataW-1:0] rdData;   // Read byte, valid with done

	// Sweeper and editor side
	modport requester
	(
		output req,
		output acc,
		input  done,
		input  rdData
	);

	// Arbiter side, also used by monitors
	modport arbiter
	(
		input  req,
		input  acc,
		output done,
		output rdData
	);

endinterface

// File: src/rtcMenuTop.sv
module rtcMenuTop
(
	input  logic                     CLK,
	input  logic                     RST,
	input  logic                     irq,
	input  logic                     left,
	input  logic                     right,
	input  logic                     up,
	input  logic                     down,
	input  logic                     centre,
	input  logic                     rtcDone,
	input  logic [rtcPkg::dataW-1:0] rtcRdData,
	output logic                     rtcReq,
	output logic [rtcPkg::addrW-1:0] rtcAddr,
	output logic [rtcPkg::dataW-1:0] rtcWrData,
	output logic                     rtcWrite,
	output logic [rtcPkg::ptrW-1:0]  punt,
	output logic [rtcPkg::dataW-1:0] curVal,
	output logic                     alarm,
	output logic                     stw
);

	logic commit;       // Centre pressed, command write pending

	// One bus per requester
	rtcBusIf sweepBus();
	rtcBusIf editBus();

	////////////////////////////////////////////////// Requesters
	rtcSweeper i_sweeper
	(
		.CLK    (CLK),
		.RST    (RST),
		.bus    (sweepBus.requester),
		.commit (commit)
	);

	menuEditor i_editor
	(
		.CLK    (CLK),
		.RST    (RST),
		.left   (left),
		.right  (right),
		.up     (up),
		.down   (down),
		.centre (centre),
		.curVal (curVal),
		.bus    (editBus.requester),
		.punt   (punt),
		.commit (commit)
	);

	////////////////////////////////////////////////// Bus and shadow bank
	rtcBusArbiter i_arbiter
	(
		.CLK       (CLK),
		.RST       (RST),
		.sweepBus  (sweepBus.arbiter),
		.editBus   (editBus.arbiter),
		.rtcReq    (rtcReq),
		.rtcAddr   (rtcAddr),
		.rtcWrData (rtcWrData),
		.rtcWrite  (rtcWrite),
		.rtcDone   (rtcDone),
		.rtcRdData (rtcRdData)
	);

	// Snoops sweeper reads
	shadowRegs i_shadow
	(
		.CLK      (CLK),
		.RST      (RST),
		.sweepBus (sweepBus.arbiter),
		.punt     (punt),
		.curVal   (curVal)
	);

	alarmTimer i_alarm
	(
		.CLK   (CLK),
		.RST   (RST),
		.irq   (irq),
		.alarm (alarm),
		.stw   (stw)
	);

endmodule

// File: src/rtcPkg.sv
package rtcPkg;

	// Bus widths
	localparam int addrW = 8;                       // RTC register address
	localparam int dataW = 8;                       // RTC data byte
	localparam int ptrW = 7;                        // Edit pointer, map fits in 7 bits

	// Address map, two contiguous windows
	localparam logic [addrW-1:0] firstLo = 8'h21;   // Time registers start
	localparam logic [addrW-1:0] lastLo = 8'h27;
	localparam logic [addrW-1:0] firstHi = 8'h41;   // Date/alarm registers start
	localparam logic [addrW-1:0] lastHi = 8'h44;
	localparam logic [addrW-1:0] cmdAddr = 8'hF0;   // Transfer command register

	// Timing
	localparam int sweepWait = 40;                  // Idle cycles between sweeps
	localparam int alarmLen = 3;                    // Alarm pulse length
	localparam int waitW = $clog2(sweepWait);
	localparam logic [waitW-1:0] waitLast = waitW'(sweepWait - 1);
	localparam int alarmW = $clog2(alarmLen);
	localparam logic [alarmW-1:0] alarmLast = alarmW'(alarmLen - 1);

	// Shadow bank
	localparam int shadowDepth = 11;                // 7 low + 4 high registers
	localparam int idxW = $clog2(shadowDepth);

	// One access on the register bus
	typedef struct packed
	{
		logic [addrW-1:0] addr;
		logic [dataW-1:0] data;
		logic write;                                 // 1 for write, 0 for read
	} rtcAccess;

	// Pointer step through the map, left counts up and right counts down
	function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] p, input logic left);
		logic [ptrW-1:0] n;
		if (left)
		begin
			if (p == lastLo[ptrW-1:0])
				n = firstHi[ptrW-1:0];                  // Jump over the gap
			else if (p == lastHi[ptrW-1:0])
				n = firstLo[ptrW-1:0];                  // Wrap to the start
			else
				n = p + 1'b1;
		end
		else
		begin
			if (p == firstHi[ptrW-1:0])
				n = lastLo[ptrW-1:0];
			else if (p == firstLo[ptrW-1:0])
				n = lastHi[ptrW-1:0];                   // Wrap to the end
			else
				n = p - 1'b1;
		end
		return n;
	endfunction

endpackage

// File: src/rtcSweeper.sv
module rtcSweeper
(
	input  logic       CLK,
	input  logic       RST,
	rtcBusIf.requester bus,
	input  logic       commit
);

	typedef enum logic [1:0]
	{
		sInit,      // Waiting for the RTC init pulse
		sSweep,     // Reading the map
		sCmd,       // Command write after a committed edit
		sWait       // Idle between sweeps
	} mainState;

	mainState state;
	logic [rtcPkg::ptrW-1:0] ptr;         // Sweep address
	logic gap;                            // Req low for one cycle after done
	logic pending;                        // Commit waiting for end of sweep
	logic [rtcPkg::waitW-1:0] waitCnt;
	logic ownDone;
	logic lastRead;
	logic sweepEnd;
	logic waitEnd;
	logic issue;
	rtcPkg::rtcAccess nextAcc;

	assign ownDone = bus.done && bus.req;                  // Done of our own request
	assign lastRead = ptr == rtcPkg::lastHi[rtcPkg::ptrW-1:0];
	assign sweepEnd = (state == sSweep) && ownDone && lastRead;
	assign waitEnd = (state == sWait) && (waitCnt == rtcPkg::waitLast);
	assign issue = ((state == sSweep) || (state == sCmd)) && !bus.req && !gap;

	// Read at the sweep address, or the command write with zero data
	always_comb
	begin
		nextAcc.addr = {{(rtcPkg::addrW - rtcPkg::ptrW){1'b0}}, ptr};
		nextAcc.data = '0;
		nextAcc.write = 1'b0;
		if (state == sCmd)
		begin
			nextAcc.addr = rtcPkg::cmdAddr;
			nextAcc.write = 1'b1;
		end
	end

	////////////////////////////////////////////////// Main FSM
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			state <= sInit;
		else
		begin
			case (state)
				sInit:
					if (bus.done)                              // Init finished pulse
						state <= sSweep;
				sSweep:
					if (sweepEnd)
						state <= pending ? sCmd : sWait;
				sCmd:
					if (ownDone)
						state <= sWait;
				sWait:
					if (waitEnd)
						state <= sSweep;                       // Next sweep
				default:
					state <= sInit;
			endcase
		end
	end

	// Commit is held until the command write completes
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			pending <= 1'b0;
		else if (commit)
			pending <= 1'b1;
		else if ((state == sCmd) && ownDone)
			pending <= 1'b0;
	end

	////////////////////////////////////////////////// Address stepping
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
		begin
			bus.req <= 1'b0;
			gap <= 1'b0;
			ptr <= rtcPkg::firstLo[rtcPkg::ptrW-1:0];
		end
		else
		begin
			gap <= ownDone;
			if (ownDone)
			begin
				bus.req <= 1'b0;
				// Step the map, lastHi wraps back to firstLo
				if (state == sSweep)
					ptr <= rtcPkg::nextPtr(ptr, 1'b1);
			end
			else if (issue)
				bus.req <= 1'b1;
		end
	end

	// Access payload, stable while req is high
	always_ff @(posedge CLK)
	begin
		if (issue)
			bus.acc <= nextAcc;
	end

	////////////////////////////////////////////////// Wait counter
	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			waitCnt <= '0;
		else if ((state == sWait) && !waitEnd)
			waitCnt <= waitCnt + 1'b1;
		else
			waitCnt <= '0;                                 // Ready for the next wait
	end

endmodule

// File: src/shadowRegs.sv
module shadowRegs
(
	input  logic                     CLK,
	input  logic                     RST,
	rtcBusIf.arbiter                 sweepBus,   // Watched only
	input  logic [rtcPkg::ptrW-1:0]  punt,
	output logic [rtcPkg::dataW-1:0] curVal
);

	logic [rtcPkg::dataW-1:0] mem [rtcPkg::shadowDepth];
	logic [rtcPkg::shadowDepth-1:0] filled;         // Entry read at least once
	logic [rtcPkg::addrW-1:0] rdAddr;
	logic [rtcPkg::idxW-1:0] wrIdx;
	logic [rtcPkg::idxW-1:0] rdIdx;
	logic rdHit;
	logic capture;

	// Address inside one of the two windows
	function automatic logic inMap(input logic [rtcPkg::addrW-1:0] a);
		return ((a >= rtcPkg::firstLo) && (a <= rtcPkg::lastLo)) ||
			((a >= rtcPkg::firstHi) && (a <= rtcPkg::lastHi));
	endfunction

	// Low window to 0..6, high window follows on
	function automatic logic [rtcPkg::idxW-1:0] mapIdx(input logic [rtcPkg::addrW-1:0] a);
		logic [rtcPkg::addrW-1:0] off;
		if (a <= rtcPkg::lastLo)
			off = a - rtcPkg::firstLo;
		else
			off = a - rtcPkg::firstHi + rtcPkg::lastLo - rtcPkg::firstLo + 1'b1;
		return off[rtcPkg::idxW-1:0];
	endfunction

	assign rdAddr = {{(rtcPkg::addrW - rtcPkg::ptrW){1'b0}}, punt};
	assign rdIdx = mapIdx(rdAddr);
	assign rdHit = inMap(rdAddr) && filled[rdIdx];
	assign wrIdx = mapIdx(sweepBus.acc.addr);

	// Sweeper read completing on a mapped address
	assign capture = sweepBus.done && sweepBus.req && !sweepBus.acc.write &&
		inMap(sweepBus.acc.addr);

	always_ff @(posedge CLK)
	begin
		if (capture)
			mem[wrIdx] <= sweepBus.rdData;
	end

	always_ff @(posedge CLK or posedge RST)
	begin
		if (RST)
			filled <= '0;
		else if (capture)
			filled[wrIdx] <= 1'b1;
	end

	assign curVal = rdHit ? mem[rdIdx] : '0;       // Zero until first sweep

endmodule
